// File: symb_rate_pkg.sv
/* Symbol rate divider package
   Rate selections, MMI register map, request/response and stream beat types */

package symb_rate_pkg;

    //////////////////////////////
    // Rate selection

    localparam int num_symb_rates = 3;

    typedef enum logic [1:0] {
        rate_quarter = 2'd0,
        rate_half    = 2'd1,
        rate_full    = 2'd2
    } rate_sel_t;

    // Number of times each input sample is sent
    function automatic int repeat_count(input rate_sel_t sel);
        case (sel)
            rate_quarter: return 4;
            rate_half:    return 2;
            default:      return 1;
        endcase
    endfunction

    //////////////////////////////
    // MMI register map

    localparam int mmi_addr_nb = 4;
    localparam int mmi_data_nb = 32;

    localparam logic [mmi_addr_nb-1:0] addr_version       = 4'd0;
    localparam logic [mmi_addr_nb-1:0] addr_symb_rate     = 4'd1;
    localparam logic [mmi_addr_nb-1:0] addr_symb_rate_sel = 4'd2;
    localparam int                     total_regs         = 3;

    localparam logic [mmi_data_nb-1:0] module_version = 32'd1;

    typedef struct packed {
        logic                   wvalid;
        logic [mmi_addr_nb-1:0] waddr;
        logic [mmi_data_nb-1:0] wdata;
        logic                   arvalid;
        logic [mmi_addr_nb-1:0] raddr;
    } mmi_req_t;

    typedef struct packed {
        logic                   rvalid;
        logic [mmi_data_nb-1:0] rdata;
    } mmi_rsp_t;

    //////////////////////////////
    // Stream payload

    typedef struct packed {
        logic [15:0] i;
        logic [15:0] q;
    } iq_sample_t;

endpackage

// File: symb_rate_mmi_regs.sv
/* Symbol rate register block
   Holds the requested rate in Msps and maps it to a rate selection */

`timescale 1ns/10ps

module symb_rate_mmi_regs #(
    parameter int                    SYMB_RATE_MSPS [0:symb_rate_pkg::num_symb_rates-1] =
                                         '{25, 50, 100},
    parameter symb_rate_pkg::rate_sel_t DEFAULT_SYMB_RATE_SEL = symb_rate_pkg::rate_full
) (
    input  logic                      clk_mmi,
    input  logic                      sresetn_mmi_interconnect,
    input  symb_rate_pkg::mmi_req_t   mmi_req,
    input  logic                      rready,
    output symb_rate_pkg::mmi_rsp_t   mmi_rsp,
    output logic                      wready,
    output logic                      arready,
    output symb_rate_pkg::rate_sel_t  rate_sel,
    input  symb_rate_pkg::rate_sel_t  rate_sel_rb
);

    //////////////////////////////
    // Rate decode

    // Unknown rates fall back to the default selection
    function automatic symb_rate_pkg::rate_sel_t symb_rate_to_sel(
        input logic [symb_rate_pkg::mmi_data_nb-1:0] rate_msps
    );
        symb_rate_pkg::rate_sel_t sel;
        sel = DEFAULT_SYMB_RATE_SEL;
        for (int i = 0; i < symb_rate_pkg::num_symb_rates; i++) begin
            if (rate_msps == symb_rate_pkg::mmi_data_nb'(SYMB_RATE_MSPS[i])) begin
                sel = symb_rate_pkg::rate_sel_t'(i);
            end
        end
        return sel;
    endfunction

    logic [symb_rate_pkg::mmi_data_nb-1:0] symb_rate;
    logic                                  rvalid;
    logic [symb_rate_pkg::mmi_data_nb-1:0] rdata;
    symb_rate_pkg::rate_sel_t              rb_meta;
    symb_rate_pkg::rate_sel_t              rb_sync;

    assign wready   = sresetn_mmi_interconnect;
    assign arready  = sresetn_mmi_interconnect;
    assign rate_sel = symb_rate_to_sel(symb_rate);
    assign mmi_rsp  = '{rvalid: rvalid, rdata: rdata};

    //////////////////////////////
    // Register write and read response

    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi_interconnect) begin
            symb_rate <= symb_rate_pkg::mmi_data_nb'(SYMB_RATE_MSPS[DEFAULT_SYMB_RATE_SEL]);
            rvalid    <= 1'b0;
        end else begin
            // Only the rate register is writable
            if (mmi_req.wvalid && wready && mmi_req.waddr == symb_rate_pkg::addr_symb_rate) begin
                symb_rate <= mmi_req.wdata;
            end

            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (mmi_req.arvalid && arready) begin
                rvalid <= 1'b1;
            end
        end
    end

    // Read data, undefined addresses return zero
    always_ff @(posedge clk_mmi) begin
        if (mmi_req.arvalid && arready) begin
            case (mmi_req.raddr)
                symb_rate_pkg::addr_version:       rdata <= symb_rate_pkg::module_version;
                symb_rate_pkg::addr_symb_rate:     rdata <= symb_rate;
                symb_rate_pkg::addr_symb_rate_sel: rdata <= symb_rate_pkg::mmi_data_nb'(rb_sync);
                default:                           rdata <= '0;
            endcase
        end
    end

    //////////////////////////////
    // Selection readback from the sample domain

    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi_interconnect) begin
            rb_meta <= DEFAULT_SYMB_RATE_SEL;
            rb_sync <= DEFAULT_SYMB_RATE_SEL;
        end else begin
            rb_meta <= rate_sel_rb;
            rb_sync <= rb_meta;
        end
    end

endmodule

// File: symb_rate_sel_sync.sv
/* Rate selection clock crossing
   Sends the selection to the sample domain on change with a toggle handshake */

`timescale 1ns/10ps

module symb_rate_sel_sync #(
    parameter symb_rate_pkg::rate_sel_t DEFAULT_SYMB_RATE_SEL = symb_rate_pkg::rate_full
) (
    input  logic                     clk_mmi,
    input  logic                     sresetn_mmi_interconnect,
    input  logic                     clk_sample,
    input  logic                     sresetn_sample_device,
    input  symb_rate_pkg::rate_sel_t in_sel,
    output symb_rate_pkg::rate_sel_t out_sel,
    output logic                     out_changed
);

    symb_rate_pkg::rate_sel_t src_sel;
    logic                     src_toggle;
    logic                     busy;
    logic                     ack_meta;
    logic                     ack_sync;
    logic                     tgl_meta;
    logic                     tgl_sync;
    logic                     dst_toggle;

    //////////////////////////////
    // Source side

    always_ff @(posedge clk_mmi) begin
        if (!sresetn_mmi_interconnect) begin
            src_sel    <= DEFAULT_SYMB_RATE_SEL;
            src_toggle <= 1'b0;
            busy       <= 1'b0;
            ack_meta   <= 1'b0;
            ack_sync   <= 1'b0;
        end else begin
            ack_meta <= dst_toggle;
            ack_sync <= ack_meta;
            if (busy) begin
                // Transfer done once the echoed toggle matches
                if (ack_sync == src_toggle) begin
                    busy <= 1'b0;
                end
            end else if (in_sel != src_sel) begin
                src_sel    <= in_sel;
                src_toggle <= ~src_toggle;
                busy       <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // Destination side

    // src_sel is stable while the toggle is in flight
    always_ff @(posedge clk_sample) begin
        if (!sresetn_sample_device) begin
            tgl_meta    <= 1'b0;
            tgl_sync    <= 1'b0;
            dst_toggle  <= 1'b0;
            out_sel     <= DEFAULT_SYMB_RATE_SEL;
            out_changed <= 1'b0;
        end else begin
            tgl_meta    <= src_toggle;
            tgl_sync    <= tgl_meta;
            dst_toggle  <= tgl_sync;
            out_changed <= tgl_sync != dst_toggle;
            if (tgl_sync != dst_toggle) begin
                out_sel <= src_sel;
            end
        end
    end

endmodule

// File: symb_rate_hold_core.sv
/* Sample hold core
   Repeats each accepted stream beat by the selected rate factor */

`timescale 1ns/10ps

module symb_rate_hold_core #(
    parameter type                      sample_t              = symb_rate_pkg::iq_sample_t,
    parameter symb_rate_pkg::rate_sel_t DEFAULT_SYMB_RATE_SEL = symb_rate_pkg::rate_full
) (
    input  logic                     clk_sample,
    input  logic                     sresetn_sample_device,
    input  symb_rate_pkg::rate_sel_t rate_sel,

    input  sample_t                  in_data,
    input  logic                     in_last,
    input  logic                     in_valid,
    output logic                     in_ready,

    output sample_t                  out_data,
    output logic                     out_last,
    output logic                     out_valid,
    input  logic                     out_ready
);

    //////////////////////////////
    // Declarations

    // Repeat index of the final copy, i.e. repeat count minus one
    function automatic logic [1:0] final_index(input symb_rate_pkg::rate_sel_t sel);
        int count;
        count = symb_rate_pkg::repeat_count(sel);
        return 2'(count - 1);
    endfunction

    sample_t    beat_data;
    logic       beat_last;
    logic       beat_valid;
    logic [1:0] rep_cnt;
    logic [1:0] rep_final;
    logic       final_rep;
    logic       in_accept;
    logic       out_take;

    //////////////////////////////
    // Handshake

    assign final_rep = rep_cnt == rep_final;
    assign out_take  = beat_valid && out_ready;

    // Free slot, or the last repeat leaves this cycle
    assign in_ready  = !beat_valid || (out_ready && final_rep);
    assign in_accept = in_valid && in_ready;

    assign out_valid = beat_valid;
    assign out_data  = beat_data;
    assign out_last  = beat_valid && beat_last && final_rep;

    //////////////////////////////
    // Control

    // Factor is latched at acceptance and kept for all repeats
    always_ff @(posedge clk_sample) begin
        if (!sresetn_sample_device) begin
            beat_valid <= 1'b0;
            rep_cnt    <= 2'd0;
            rep_final  <= final_index(DEFAULT_SYMB_RATE_SEL);
        end else begin
            if (in_accept) begin
                beat_valid <= 1'b1;
                rep_cnt    <= 2'd0;
                rep_final  <= final_index(rate_sel);
            end else if (out_take) begin
                if (final_rep) begin
                    beat_valid <= 1'b0;
                end else begin
                    rep_cnt <= rep_cnt + 2'd1;
                end
            end
        end
    end

    //////////////////////////////
    // Payload

    always_ff @(posedge clk_sample) begin
        if (in_accept) begin
            beat_data <= in_data;
            beat_last <= in_last;
        end
    end

endmodule

// File: symb_rate_divider_top.sv
/* Transmit symbol rate divider
   MMI rate control with a sample-domain hold of each input beat */

`timescale 1ns/10ps

module symb_rate_divider_top #(
    parameter int                       SYMB_RATE_MSPS [0:symb_rate_pkg::num_symb_rates-1] =
                                            '{25, 50, 100},
    parameter symb_rate_pkg::rate_sel_t DEFAULT_SYMB_RATE_SEL = symb_rate_pkg::rate_full,
    parameter type                      sample_t              = symb_rate_pkg::iq_sample_t
) (
    input  logic                    clk_mmi,
    input  logic                    sresetn_mmi_interconnect,
    input  logic                    clk_sample,
    input  logic                    sresetn_sample_device,

    // MMI control port
    input  symb_rate_pkg::mmi_req_t mmi_req,
    input  logic                    rready,
    output symb_rate_pkg::mmi_rsp_t mmi_rsp,
    output logic                    wready,
    output logic                    arready,

    // Sample stream
    input  sample_t                 in_data,
    input  logic                    in_last,
    input  logic                    in_valid,
    output logic                    in_ready,
    output sample_t                 out_data,
    output logic                    out_last,
    output logic                    out_valid,
    input  logic                    out_ready
);

    symb_rate_pkg::rate_sel_t rate_sel_mmi;
    symb_rate_pkg::rate_sel_t rate_sel_sample;
    logic                     sel_changed;

    symb_rate_mmi_regs #(
        .SYMB_RATE_MSPS        (SYMB_RATE_MSPS),
        .DEFAULT_SYMB_RATE_SEL (DEFAULT_SYMB_RATE_SEL)
    ) i_regs (
        .clk_mmi                  (clk_mmi),
        .sresetn_mmi_interconnect (sresetn_mmi_interconnect),
        .mmi_req                  (mmi_req),
        .rready                   (rready),
        .mmi_rsp                  (mmi_rsp),
        .wready                   (wready),
        .arready                  (arready),
        .rate_sel                 (rate_sel_mmi),
        .rate_sel_rb              (rate_sel_sample)
    );

    // out_changed marks each completed transfer
    symb_rate_sel_sync #(
        .DEFAULT_SYMB_RATE_SEL (DEFAULT_SYMB_RATE_SEL)
    ) i_sync (
        .clk_mmi                  (clk_mmi),
        .sresetn_mmi_interconnect (sresetn_mmi_interconnect),
        .clk_sample               (clk_sample),
        .sresetn_sample_device    (sresetn_sample_device),
        .in_sel                   (rate_sel_mmi),
        .out_sel                  (rate_sel_sample),
        .out_changed              (sel_changed)
    );

    symb_rate_hold_core #(
        .sample_t              (sample_t),
        .DEFAULT_SYMB_RATE_SEL (DEFAULT_SYMB_RATE_SEL)
    ) i_core (
        .clk_sample            (clk_sample),
        .sresetn_sample_device (sresetn_sample_device),
        .rate_sel              (rate_sel_sample),
        .in_data               (in_data),
        .in_last               (in_last),
        .in_valid              (in_valid),
        .in_ready              (in_ready),
        .out_data              (out_data),
        .out_last              (out_last),
        .out_valid             (out_valid),
        .out_ready             (out_ready)
    );

endmodule

// File: tb_clk_gen.sv
/* Testbench clock and reset generator
   Free-running mmi and sample clocks with synchronous active-low resets */

`timescale 1ns/10ps

module tb_clk_gen #(
    parameter real MMI_PERIOD    = 40.0,
    parameter real SAMPLE_PERIOD = 25.0,
    parameter int  RESET_CYCLES  = 4
) (
    output logic clk_mmi,
    output logic clk_sample,
    output logic sresetn_mmi_interconnect,
    output logic sresetn_sample_device
);

    initial begin
        clk_mmi = 1'b0;
        forever #(MMI_PERIOD / 2.0) clk_mmi = ~clk_mmi;
    end

    initial begin
        clk_sample = 1'b0;
        forever #(SAMPLE_PERIOD / 2.0) clk_sample = ~clk_sample;
    end

    // Each reset is released on a falling edge of its own clock
    initial begin
        sresetn_mmi_interconnect = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_mmi);
        @(negedge clk_mmi);
        sresetn_mmi_interconnect = 1'b1;
    end

    initial begin
        sresetn_sample_device = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_sample);
        @(negedge clk_sample);
        sresetn_sample_device = 1'b1;
    end

endmodule

// File: tb_symb_rate_divider.sv
/* Symbol rate divider testbench
   Directed tests of the MMI registers and the sample hold against a queue model */

`timescale 1ns/10ps

module tb_symb_rate_divider;

    localparam int TIMEOUT_CYCLES = 20000;

    logic                       clk_mmi;
    logic                       clk_sample;
    logic                       sresetn_mmi_interconnect;
    logic                       sresetn_sample_device;
    symb_rate_pkg::mmi_req_t    mmi_req;
    logic                       rready;
    symb_rate_pkg::mmi_rsp_t    mmi_rsp;
    logic                       wready;
    logic                       arready;
    symb_rate_pkg::iq_sample_t  in_data;
    logic                       in_last;
    logic                       in_valid;
    logic                       in_ready;
    symb_rate_pkg::iq_sample_t  out_data;
    logic                       out_last;
    logic                       out_valid;
    logic                       out_ready;

    integer                     seed = 62;
    int                         check_count = 0;
    int                         mismatch_count = 0;
    int                         other_errors = 0;
    int                         cycle_count;
    int                         rate_msps;
    symb_rate_pkg::rate_sel_t   expected_sel;
    logic [31:0]                exp_data [$];
    logic                       exp_last [$];

    tb_clk_gen i_clk_gen (
        .clk_mmi                  (clk_mmi),
        .clk_sample               (clk_sample),
        .sresetn_mmi_interconnect (sresetn_mmi_interconnect),
        .sresetn_sample_device    (sresetn_sample_device)
    );

    symb_rate_divider_top i_dut (
        .clk_mmi                  (clk_mmi),
        .sresetn_mmi_interconnect (sresetn_mmi_interconnect),
        .clk_sample               (clk_sample),
        .sresetn_sample_device    (sresetn_sample_device),
        .mmi_req                  (mmi_req),
        .rready                   (rready),
        .mmi_rsp                  (mmi_rsp),
        .wready                   (wready),
        .arready                  (arready),
        .in_data                  (in_data),
        .in_last                  (in_last),
        .in_valid                 (in_valid),
        .in_ready                 (in_ready),
        .out_data                 (out_data),
        .out_last                 (out_last),
        .out_valid                (out_valid),
        .out_ready                (out_ready)
    );

    //////////////////////////////
    // Checking helpers

    // Copies of each input beat: full once, half twice, quarter four times
    function automatic int copies_for(input symb_rate_pkg::rate_sel_t sel);
        case (sel)
            symb_rate_pkg::rate_quarter: return 4;
            symb_rate_pkg::rate_half:    return 2;
            default:                     return 1;
        endcase
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic report_error(input string what);
        other_errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    //////////////////////////////
    // MMI access

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        @(negedge clk_mmi);
        check(wready, 1'b1, "wready during write");
        mmi_req.wvalid = 1'b1;
        mmi_req.waddr  = addr;
        mmi_req.wdata  = data;
        @(negedge clk_mmi);
        mmi_req.wvalid = 1'b0;
    endtask

    // Response is expected one cycle after arvalid
    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        int waited;
        @(negedge clk_mmi);
        check(arready, 1'b1, "arready during read");
        mmi_req.arvalid = 1'b1;
        mmi_req.raddr   = addr;
        rready          = 1'b1;
        @(negedge clk_mmi);
        mmi_req.arvalid = 1'b0;
        waited = 0;
        while (!mmi_rsp.rvalid && waited < 8) begin
            @(negedge clk_mmi);
            waited++;
        end
        data = mmi_rsp.rdata;
        if (!mmi_rsp.rvalid) begin
            report_error("Read response never arrived");
        end else begin
            check(waited, 0, "read latency beyond one cycle");
        end
        @(negedge clk_mmi);
        rready = 1'b0;
        check(mmi_rsp.rvalid, 1'b0, "rvalid after read handshake");
    endtask

    task automatic expect_reg(input logic [3:0] addr, input logic [31:0] expected,
                              input string what);
        logic [31:0] value;
        read_reg(addr, value);
        check(value, expected, what);
    endtask

    // Write a rate, wait for the crossing pulse, then poll the selection readback
    task automatic set_rate(input int msps, input symb_rate_pkg::rate_sel_t sel);
        logic [31:0] value;
        int          polls;
        int          waited;
        write_reg(symb_rate_pkg::addr_symb_rate, msps);
        rate_msps = msps;
        if (sel != expected_sel) begin
            waited = 0;
            while (!i_dut.sel_changed && waited < 20) begin
                @(negedge clk_sample);
                waited++;
            end
            if (!i_dut.sel_changed) begin
                report_error("Selection change pulse never arrived in the sample domain");
            end
        end
        value = 32'hffff_ffff;
        polls = 0;
        while (value != 32'(sel) && polls < 40) begin
            read_reg(symb_rate_pkg::addr_symb_rate_sel, value);
            polls++;
        end
        check(value, 32'(sel), "selection readback after rate write");
        expected_sel = sel;
    endtask

    //////////////////////////////
    // Stream driver and model

    task automatic run_stream(input int beats, input bit random_flow);
        int sent;
        int cycles;
        int copies;
        bit pending;
        sent    = 0;
        cycles  = 0;
        pending = 1'b0;
        exp_data.delete();
        exp_last.delete();
        while ((sent < beats || exp_data.size() > 0) && cycles < beats * 40 + 50) begin
            @(negedge clk_sample);
            if (!pending) begin
                in_valid = 1'b0;
                if (sent < beats && (!random_flow || ($random(seed) & 1))) begin
                    in_valid = 1'b1;
                    in_data  = $random(seed);
                    in_last  = (sent % 6 == 5) || (sent == beats - 1);
                    pending  = 1'b1;
                end
            end
            out_ready = random_flow ? 1'($random(seed) & 1) : 1'b1;
            #1;
            // Transfers that happen on the coming rising edge
            if (out_valid && out_ready) begin
                if (exp_data.size() == 0) begin
                    report_error("Output beat appeared with no input beat behind it");
                end else begin
                    check(out_data, exp_data.pop_front(), "output data");
                    check(out_last, exp_last.pop_front(), "output last");
                end
            end
            if (in_valid && in_ready) begin
                copies = copies_for(expected_sel);
                for (int k = 0; k < copies; k++) begin
                    exp_data.push_back(in_data);
                    exp_last.push_back(in_last && k == copies - 1);
                end
                sent++;
                pending = 1'b0;
            end
            cycles++;
        end
        if (sent < beats || exp_data.size() > 0) begin
            report_error("Stream stalled before all beats came out");
        end
        @(negedge clk_sample);
        in_valid  = 1'b0;
        in_last   = 1'b0;
        out_ready = 1'b1;
        #1;
        check(out_valid, 1'b0, "output idle after burst");
    endtask

    //////////////////////////////
    // Tests

    task automatic test_reset_defaults();
        check(mmi_rsp.rvalid, 1'b0, "rvalid after reset");
        check(out_valid, 1'b0, "out_valid after reset");
        check(in_ready, 1'b1, "in_ready after reset");
        check(i_dut.sel_changed, 1'b0, "out_changed after reset");
        expect_reg(symb_rate_pkg::addr_version, 32'd1, "version register");
        expect_reg(symb_rate_pkg::addr_symb_rate, 32'd100, "default rate");
        expect_reg(symb_rate_pkg::addr_symb_rate_sel, 32'(symb_rate_pkg::rate_full),
                   "default selection");
        run_stream(8, 1'b0);
    endtask

    task automatic test_rate_writes();
        set_rate(50, symb_rate_pkg::rate_half);
        expect_reg(symb_rate_pkg::addr_symb_rate, 32'd50, "rate after writing 50");
        set_rate(25, symb_rate_pkg::rate_quarter);
        expect_reg(symb_rate_pkg::addr_symb_rate, 32'd25, "rate after writing 25");
    endtask

    task automatic test_repeat_counts();
        set_rate(100, symb_rate_pkg::rate_full);
        run_stream(12, 1'b0);
        set_rate(50, symb_rate_pkg::rate_half);
        run_stream(12, 1'b0);
        set_rate(25, symb_rate_pkg::rate_quarter);
        run_stream(12, 1'b0);
    endtask

    // 77 Msps is not in the table, so the default applies
    task automatic test_unknown_rate();
        set_rate(77, symb_rate_pkg::rate_full);
        expect_reg(symb_rate_pkg::addr_symb_rate, 32'd77, "unknown rate kept in register");
    endtask

    task automatic test_address_rules();
        expect_reg(4'd3, 32'd0, "read of undefined address 3");
        expect_reg(4'd15, 32'd0, "read of undefined address 15");
        write_reg(symb_rate_pkg::addr_version, 32'd7);
        expect_reg(symb_rate_pkg::addr_version, 32'd1, "version after write");
        write_reg(symb_rate_pkg::addr_symb_rate_sel, 32'd0);
        expect_reg(symb_rate_pkg::addr_symb_rate_sel, 32'(expected_sel),
                   "selection after write");
        write_reg(4'd9, 32'd50);
        expect_reg(symb_rate_pkg::addr_symb_rate, rate_msps, "rate after undefined write");
    endtask

    task automatic test_back_pressure();
        set_rate(25, symb_rate_pkg::rate_quarter);
        run_stream(24, 1'b1);
    endtask

    //////////////////////////////
    // Sequence and timeout

    initial begin
        mmi_req      = '0;
        rready       = 1'b0;
        in_data      = '0;
        in_last      = 1'b0;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        rate_msps    = 100;
        expected_sel = symb_rate_pkg::rate_full;
        wait (sresetn_mmi_interconnect && sresetn_sample_device);
        repeat (2) @(negedge clk_mmi);

        test_reset_defaults();
        test_rate_writes();
        test_repeat_counts();
        test_unknown_rate();
        test_address_rules();
        test_back_pressure();

        $display("Summary: %0d checks, %0d mismatches, %0d other errors",
                 check_count, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_mmi);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d mmi cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: filelist.f
symb_rate_pkg.sv
symb_rate_mmi_regs.sv
symb_rate_sel_sync.sv
symb_rate_hold_core.sv
symb_rate_divider_top.sv
tb_clk_gen.sv
tb_symb_rate_divider.sv

// File: Bender.yml
package:
  name: symb_rate_divider

sources:
  # Design, in compile order
  - symb_rate_pkg.sv
  - symb_rate_mmi_regs.sv
  - symb_rate_sel_sync.sv
  - symb_rate_hold_core.sv
  - symb_rate_divider_top.sv

  # Testbench
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_symb_rate_divider.sv
